//--- project.f
smpc_pkg.sv
smpc_oreg_ram.sv
smpc_host_regs.sv
smpc_cmd_seq.sv
smpc_rtc.sv
smpc_top.sv
tb_clock.sv
tb_smpc.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module tb_smpc -o tb_smpc
	./obj_dir/tb_smpc | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- tb_smpc.sv
`default_nettype none

module tb_smpc import smpc_pkg::*; ();

	logic       CLK;
	logic       RST_N;
	logic       ce;
	bus_req_t   bus;
	byte_t      rd_data;
	area_code_t area_code;
	sys_reset_t sys_reset;

	sys_reset_t exp_rst;
	logic       exp_ste;
	logic       exp_resd;
	byte_t      oreg [0:31];
	int         errors = 0;
	int         timeouts = 0;
	int         mirq_lows = 0;
	int         nmi_lows = 0;

	tb_clock clock0 (
		.CLK   (CLK),
		.RST_N (RST_N)
	);

	smpc_top #(
		.TICKS_PER_SEC (5000)
	) dut0 (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ce        (ce),
		.bus       (bus),
		.rd_data   (rd_data),
		.area_code (area_code),
		.sys_reset (sys_reset)
	);

	// Low cycles seen on the interrupt lines
	always @(negedge CLK) begin
		if (RST_N) begin
			if (!sys_reset.mirq_n)
				mirq_lows++;
			if (!sys_reset.mshnmi_n)
				nmi_lows++;
		end
	end

	task automatic report_mismatch(input string what, input byte_t got, input byte_t exp);
		errors++;
		$display("error at time %0t: %s is %02h, expected %02h", $time, what, got, exp);
	endtask

	task automatic bus_write(input reg_addr_t addr, input byte_t data);
		bus.wr_stb = 1'b1;
		bus.addr   = addr;
		bus.wdata  = data;
		@(negedge CLK);
		bus.wr_stb = 1'b0;
	endtask

	task automatic bus_read(input reg_addr_t addr, output byte_t data);
		bus.rd_stb = 1'b1;
		bus.addr   = addr;
		@(negedge CLK);
		bus.rd_stb = 1'b0;
		data       = rd_data;   // Loaded at the edge after the strobe
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (RST_N !== 1'b1 && n < 100) begin
			@(negedge CLK);
			n++;
		end
		if (RST_N !== 1'b1) begin
			timeouts++;
			$display("timeout: reset was never released");
		end
		@(negedge CLK);
	endtask

	task automatic run_cmd(input byte_t code);
		int    waited;
		byte_t sf;
		waited = 0;
		bus_write(ADDR_SF, 8'h01);
		bus_write(ADDR_COMREG, code);
		bus_read(ADDR_SF, sf);
		while (sf[0] && waited < 20000) begin
			repeat (20) @(negedge CLK);
			waited += 20;
			bus_read(ADDR_SF, sf);
		end
		if (sf[0]) begin
			timeouts++;
			$display("timeout: command %02h did not clear SF within 20000 cycles", code);
		end
	endtask

	task automatic read_oregs();
		int i;
		for (i = 0; i < 32; i++)
			bus_read(reg_addr_t'(OREG_BASE + i), oreg[i]);
	endtask

	task automatic run_intback();
		int    m0;
		byte_t v;
		m0 = mirq_lows;
		bus_write(ADDR_IREG2, INTBACK_KEY);
		run_cmd(CMD_INTBACK);
		if (mirq_lows - m0 != 1) begin
			errors++;
			$display("error at time %0t: INTBACK gave %0d mirq_n low cycles, expected 1",
				$time, mirq_lows - m0);
		end
		bus_read(ADDR_SR, v);
		if (v !== 8'h4F)
			report_mismatch("SR after INTBACK", v, 8'h4F);
		read_oregs();
	endtask

	task automatic check_status();
		byte_t exp;
		int    i;
		exp = {exp_ste, exp_resd, 6'b000000};
		if (oreg[0] !== exp)
			report_mismatch("OREG0", oreg[0], exp);
		if (oreg[8] !== 8'h00)
			report_mismatch("OREG8", oreg[8], 8'h00);
		if (oreg[9] !== {4'h0, area_code})
			report_mismatch("OREG9", oreg[9], {4'h0, area_code});
		exp = {4'b0011, ~exp_rst.mshnmi_n, 2'b10, ~exp_rst.sndres_n};
		if (oreg[10] !== exp)
			report_mismatch("OREG10", oreg[10], exp);
		exp = {1'b0, ~exp_rst.cdres_n, 6'b000000};
		if (oreg[11] !== exp)
			report_mismatch("OREG11", oreg[11], exp);
		for (i = 12; i < 31; i++) begin
			if (oreg[i] !== 8'h00)
				report_mismatch($sformatf("OREG%0d", i), oreg[i], 8'h00);
		end
		if (oreg[31] !== 8'h10)
			report_mismatch("OREG31", oreg[31], 8'h10);
	endtask

	task automatic check_time(input rtc_time_t a, input rtc_time_t b);
		rtc_time_t got;
		got = {oreg[1], oreg[2], oreg[3], oreg[4], oreg[5], oreg[6], oreg[7]};
		if (got !== a && got !== b) begin
			errors++;
			$display("error at time %0t: RTC reads %h, expected %h or %h", $time, got, a, b);
		end
	endtask

	task automatic load_time(input rtc_time_t t);
		logic [55:0] v;
		int          i;
		v = t;
		for (i = 0; i < 7; i++)
			bus_write(reg_addr_t'(ADDR_IREG0 + i), v[55 - 8 * i -: 8]);
		run_cmd(CMD_SETTIME);
		exp_ste = 1'b1;
	endtask

	function automatic void apply_power(input byte_t code);
		case (code)
			CMD_MSHON:  exp_rst.mshres_n = 1'b1;
			CMD_SSHON:  exp_rst.sshres_n = 1'b1;
			CMD_SSHOFF: exp_rst.sshres_n = 1'b0;
			CMD_SNDON:  exp_rst.sndres_n = 1'b1;
			CMD_SNDOFF: exp_rst.sndres_n = 1'b0;
			CMD_CDON:   exp_rst.cdres_n = 1'b1;
			CMD_CDOFF:  exp_rst.cdres_n = 1'b0;
			default: ;
		endcase
	endfunction

	task automatic check_after_reset();
		byte_t v;
		if (sys_reset !== exp_rst)
			report_mismatch("sys_reset after reset", sys_reset, exp_rst);
		bus_read(ADDR_SF, v);
		if (v !== 8'hF0)
			report_mismatch("SF after reset", v, 8'hF0);
	endtask

	task automatic cycle_power_lines();
		byte_t order [0:6];
		byte_t tmp;
		byte_t v;
		int    i;
		int    j;
		order = '{CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF, CMD_CDON, CMD_CDOFF};
		for (i = 6; i > 0; i--) begin
			j        = $urandom % (i + 1);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (i = 0; i < 7; i++) begin
			for (j = 0; j < 7; j++)
				bus_write(reg_addr_t'(ADDR_IREG0 + j), byte_t'($urandom));   // Filler
			run_cmd(order[i]);
			apply_power(order[i]);
			if (sys_reset !== exp_rst)
				report_mismatch($sformatf("sys_reset after %02h", order[i]), sys_reset, exp_rst);
			bus_read(reg_addr_t'(OREG_BASE + OREG_ECHO), v);
			if (v !== order[i])
				report_mismatch("OREG31 echo", v, order[i]);
		end
	endtask

	task automatic nmi_and_reset_flag();
		int n0;
		n0 = nmi_lows;
		run_cmd(CMD_NMIREQ);
		if (nmi_lows - n0 != 1) begin
			errors++;
			$display("error at time %0t: NMIREQ gave %0d mshnmi_n low cycles, expected 1",
				$time, nmi_lows - n0);
		end
		if (sys_reset !== exp_rst)
			report_mismatch("sys_reset after NMIREQ", sys_reset, exp_rst);
		run_cmd(CMD_RESENAB);
		exp_resd = 1'b0;
		run_intback();
		check_status();
		run_cmd(CMD_RESDISA);
		exp_resd = 1'b1;
		run_intback();
		check_status();
	endtask

	task automatic settime_and_status();
		int m0;
		load_time({16'h1999, 4'd5, 4'd12, 8'h31, 8'h23, 8'h59, 8'h59});
		run_intback();
		check_time({16'h1999, 4'd5, 4'd12, 8'h31, 8'h23, 8'h59, 8'h59},
			{16'h2000, 4'd5, 4'd1, 8'h01, 8'h00, 8'h00, 8'h00});
		check_status();
		m0 = mirq_lows;
		bus_write(ADDR_IREG2, 8'h3C);   // Wrong key
		run_cmd(CMD_INTBACK);
		if (mirq_lows != m0) begin
			errors++;
			$display("error at time %0t: INTBACK with a bad key pulsed mirq_n", $time);
		end
	endtask

	task automatic calendar_rollover();
		load_time({16'h1999, 4'd5, 4'd12, 8'h31, 8'h23, 8'h59, 8'h59});
		repeat (7500) @(negedge CLK);
		run_intback();
		check_time({16'h2000, 4'd5, 4'd1, 8'h01, 8'h00, 8'h00, 8'h00},
			{16'h2000, 4'd5, 4'd1, 8'h01, 8'h00, 8'h00, 8'h01});
		load_time({16'h1999, 4'd0, 4'd2, 8'h28, 8'h23, 8'h59, 8'h59});
		repeat (7500) @(negedge CLK);
		run_intback();
		check_time({16'h1999, 4'd0, 4'd3, 8'h01, 8'h00, 8'h00, 8'h00},
			{16'h1999, 4'd0, 4'd3, 8'h01, 8'h00, 8'h00, 8'h01});
	endtask

	initial begin
		ce        = 1'b1;
		bus       = '0;
		area_code = 4'hA;
		exp_rst   = 8'hDB;   // Power-on line values
		exp_ste   = 1'b0;
		exp_resd  = 1'b1;
		void'($urandom(93561));
		wait_reset();
		check_after_reset();
		cycle_power_lines();
		nmi_and_reset_flag();
		settime_and_status();
		calendar_rollover();
		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

module tb_clock (
	output logic CLK,
	output logic RST_N
);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial begin
		RST_N = 1'b0;
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;   // Released away from the active edge
	end

endmodule

`default_nettype wire

//--- smpc_top.sv
`default_nettype none

module smpc_top import smpc_pkg::*; #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       ce,
	input  bus_req_t   bus,
	output byte_t      rd_data,
	input  area_code_t area_code,
	output sys_reset_t sys_reset
);

	logic       cmd_stb;
	cmd_code_t  cmd;
	ireg_t      ireg;
	oreg_addr_t oreg_rd_addr;
	byte_t      oreg_q;
	byte_t      sr;
	logic       sf_clr;
	logic       time_set;
	oreg_wr_t   oreg_wr;
	rtc_time_t  now;

	smpc_host_regs host_regs0 (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.bus          (bus),
		.oreg_q       (oreg_q),
		.sr           (sr),
		.sf_clr       (sf_clr),
		.cmd_stb      (cmd_stb),
		.cmd          (cmd),
		.ireg         (ireg),
		.oreg_rd_addr (oreg_rd_addr),
		.rd_data      (rd_data)
	);

	smpc_cmd_seq cmd_seq0 (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ce        (ce),
		.cmd_stb   (cmd_stb),
		.cmd       (cmd),
		.ireg      (ireg),
		.now       (now),
		.area_code (area_code),
		.sf_clr    (sf_clr),
		.sr        (sr),
		.time_set  (time_set),
		.oreg_wr   (oreg_wr),
		.sys_reset (sys_reset)
	);

	smpc_rtc #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) rtc0 (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.ce       (ce),
		.time_set (time_set),
		.set_time (rtc_time_t'(ireg)),   // IREG0..6 already in field order
		.now      (now)
	);

	smpc_oreg_ram oreg_ram0 (
		.CLK     (CLK),
		.wr      (oreg_wr),
		.rd_addr (oreg_rd_addr),
		.q       (oreg_q)
	);

endmodule

`default_nettype wire

//--- smpc_rtc.sv
`default_nettype none

module smpc_rtc import smpc_pkg::*; #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      ce,
	input  logic      time_set,
	input  rtc_time_t set_time,
	output rtc_time_t now
);

	localparam int CNT_W = $clog2(TICKS_PER_SEC);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICKS_PER_SEC - 1);
	localparam rtc_time_t RTC_INIT = '{year: 16'h2024, dow: 4'd0, month: 4'd1,
		days: 8'h01, hour: 8'h00, minute: 8'h00, second: 8'h00};

	logic [CNT_W-1:0] presc;
	logic             sec_tick;
	logic             last_day;
	logic             c_min;
	logic             c_hour;
	logic             c_day;
	logic             c_month;
	logic             c_year;

	function automatic bcd8_t bcd_inc(input bcd8_t v);
		bcd8_t r;
		if (v[3:0] == 4'd9)
			r = {v[7:4] + 4'd1, 4'd0};
		else
			r = {v[7:4], v[3:0] + 4'd1};
		return r;
	endfunction

	// No leap years
	assign last_day = (now.month == 4'd2 && now.days == 8'h28) ||
		((now.month == 4'd4 || now.month == 4'd6 || now.month == 4'd9 ||
		now.month == 4'd11) && now.days == 8'h30) ||
		now.days == 8'h31;

	assign c_min   = sec_tick && now.second == 8'h59;
	assign c_hour  = c_min && now.minute == 8'h59;
	assign c_day   = c_hour && now.hour == 8'h23;
	assign c_month = c_day && last_day;
	assign c_year  = c_month && now.month == 4'd12;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			now      <= RTC_INIT;
			presc    <= '0;
			sec_tick <= 1'b0;
		end else if (time_set) begin
			now      <= set_time;
			presc    <= '0;                  // Full second after a load
			sec_tick <= 1'b0;
		end else if (ce) begin
			sec_tick <= (presc == CNT_LAST);
			presc    <= (presc == CNT_LAST) ? '0 : presc + 1'b1;
			if (sec_tick)
				now.second <= (now.second == 8'h59) ? 8'h00 : bcd_inc(now.second);
			if (c_min)
				now.minute <= (now.minute == 8'h59) ? 8'h00 : bcd_inc(now.minute);
			if (c_hour)
				now.hour <= (now.hour == 8'h23) ? 8'h00 : bcd_inc(now.hour);
			if (c_day)
				now.days <= last_day ? 8'h01 : bcd_inc(now.days);
			if (c_month)
				now.month <= (now.month == 4'd12) ? 4'd1 : now.month + 4'd1;
			if (c_year) begin
				now.year[7:0] <= (now.year[7:0] == 8'h99) ? 8'h00 : bcd_inc(now.year[7:0]);
				if (now.year[7:0] == 8'h99)
					now.year[15:8] <= bcd_inc(now.year[15:8]);   // Century
			end
		end
	end

	a_presc_range: assert property (@(posedge CLK) disable iff (!RST_N)
		presc <= CNT_LAST);

endmodule

`default_nettype wire

//--- smpc_cmd_seq.sv
`default_nettype none

module smpc_cmd_seq import smpc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       ce,
	input  logic       cmd_stb,
	input  cmd_code_t  cmd,
	input  ireg_t      ireg,
	input  rtc_time_t  now,
	input  area_code_t area_code,
	output logic       sf_clr,
	output byte_t      sr,
	output logic       time_set,
	output oreg_wr_t   oreg_wr,
	output sys_reset_t sys_reset
);

	// Masters running, slave and sound held in reset
	localparam sys_reset_t SYS_RESET_INIT = '{mshres_n: 1'b1, mshnmi_n: 1'b1,
		sshres_n: 1'b0, sshnmi_n: 1'b1, sysres_n: 1'b1, sndres_n: 1'b0,
		cdres_n: 1'b1, mirq_n: 1'b1};

	seq_state_t  state;
	seq_state_t  next_state;
	cmd_code_t   cur_cmd;
	logic [15:0] wait_cnt;
	oreg_addr_t  oreg_cnt;
	logic        pending;
	logic        resd;
	logic        ste;
	byte_t       status_byte;

	// INTBACK status layout
	always_comb begin
		case (oreg_cnt)
			5'd0:      status_byte = {ste, resd, 6'b000000};
			5'd1:      status_byte = now.year[15:8];
			5'd2:      status_byte = now.year[7:0];
			5'd3:      status_byte = {now.dow, now.month};
			5'd4:      status_byte = now.days;
			5'd5:      status_byte = now.hour;
			5'd6:      status_byte = now.minute;
			5'd7:      status_byte = now.second;
			5'd9:      status_byte = {4'b0000, area_code};
			5'd10:     status_byte = {4'b0011, ~sys_reset.mshnmi_n, 2'b10, ~sys_reset.sndres_n};
			5'd11:     status_byte = {1'b0, ~sys_reset.cdres_n, 6'b000000};
			OREG_ECHO: status_byte = cur_cmd;
			default:   status_byte = 8'h00;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state      <= IDLE;
			next_state <= IDLE;
			cur_cmd    <= CMD_MSHON;
			wait_cnt   <= '0;
			oreg_cnt   <= '0;
			pending    <= 1'b0;
			resd       <= 1'b1;
			ste        <= 1'b0;
			sr         <= '0;
			sf_clr     <= 1'b0;
			time_set   <= 1'b0;
			oreg_wr    <= '0;
			sys_reset  <= SYS_RESET_INIT;
		end else begin
			sf_clr     <= 1'b0;
			time_set   <= 1'b0;
			oreg_wr.we <= 1'b0;
			if (ce) begin
				case (state)
					IDLE: begin
						if (pending) begin
							pending    <= 1'b0;
							cur_cmd    <= cmd;
							oreg_cnt   <= '0;
							sr[4:0]    <= {1'b0, ireg[1][7:4]};
							wait_cnt   <= WAIT_ACCEPT;
							next_state <= COMMAND;
							state      <= WAIT;
						end
					end
					WAIT: begin
						if (wait_cnt == 16'd0)
							state <= next_state;
						else
							wait_cnt <= wait_cnt - 16'd1;
					end
					COMMAND: begin
						next_state <= EXEC;
						state      <= WAIT;
						case (cur_cmd)
							CMD_MSHON, CMD_SSHON, CMD_SSHOFF,
							CMD_SNDON, CMD_SNDOFF:              wait_cnt <= WAIT_POWER;
							CMD_CDON, CMD_CDOFF:                wait_cnt <= WAIT_CD;
							CMD_NMIREQ, CMD_RESENAB, CMD_RESDISA: wait_cnt <= WAIT_MISC;
							CMD_SETTIME:                        wait_cnt <= WAIT_SETTIME;
							CMD_INTBACK: begin
								if (ireg[2] == INTBACK_KEY)
									wait_cnt <= WAIT_INTBACK;
								else
									state <= END;            // Bad key, no data
							end
							default: state <= EXEC;
						endcase
					end
					EXEC: begin
						oreg_wr <= '{we: 1'b1, addr: OREG_ECHO, data: cur_cmd};
						state   <= END;
						case (cur_cmd)
							CMD_MSHON: begin
								sys_reset.mshres_n <= 1'b1;
								sys_reset.mshnmi_n <= 1'b1;
							end
							CMD_SSHON: begin
								sys_reset.sshres_n <= 1'b1;
								sys_reset.sshnmi_n <= 1'b1;
							end
							CMD_SSHOFF: begin
								sys_reset.sshres_n <= 1'b0;
								sys_reset.sshnmi_n <= 1'b1;
							end
							CMD_SNDON:   sys_reset.sndres_n <= 1'b1;
							CMD_SNDOFF:  sys_reset.sndres_n <= 1'b0;
							CMD_CDON:    sys_reset.cdres_n <= 1'b1;
							CMD_CDOFF:   sys_reset.cdres_n <= 1'b0;
							CMD_NMIREQ:  sys_reset.mshnmi_n <= 1'b0;
							CMD_RESENAB: resd <= 1'b0;
							CMD_RESDISA: resd <= 1'b1;
							CMD_SETTIME: begin
								ste      <= 1'b1;
								time_set <= 1'b1;
							end
							CMD_INTBACK: begin
								oreg_wr.addr <= oreg_cnt;   // One byte per cycle
								oreg_wr.data <= status_byte;
								oreg_cnt     <= oreg_cnt + 5'd1;
								if (oreg_cnt == OREG_ECHO) begin
									sr               <= 8'h4F;
									sys_reset.mirq_n <= 1'b0;
								end else begin
									state <= EXEC;
								end
							end
							default: ;
						endcase
					end
					END: begin
						sf_clr             <= 1'b1;
						sys_reset.mshnmi_n <= 1'b1;       // Ends NMI pulse
						sys_reset.mirq_n   <= 1'b1;
						state              <= IDLE;
					end
					default: state <= IDLE;
				endcase
			end
			if (cmd_stb)
				pending <= 1'b1;
		end
	end

	a_mirq_single: assert property (@(posedge CLK) disable iff (!RST_N)
		(ce && !sys_reset.mirq_n) |=> sys_reset.mirq_n);

	a_state_legal: assert property (@(posedge CLK) disable iff (!RST_N)
		state inside {IDLE, WAIT, COMMAND, EXEC, END});

endmodule

`default_nettype wire

//--- smpc_host_regs.sv
`default_nettype none

module smpc_host_regs import smpc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  bus_req_t   bus,
	input  byte_t      oreg_q,
	input  byte_t      sr,
	input  logic       sf_clr,
	output logic       cmd_stb,
	output cmd_code_t  cmd,
	output ireg_t      ireg,
	output oreg_addr_t oreg_rd_addr,
	output byte_t      rd_data
);

	logic      sf;
	reg_addr_t oreg_off;
	logic      in_oreg;

	assign oreg_off     = bus.addr - OREG_BASE;
	assign oreg_rd_addr = oreg_off[4:0];
	assign in_oreg      = (bus.addr >= OREG_BASE) && (oreg_off < 6'd32);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cmd_stb <= 1'b0;
			sf      <= 1'b0;
			ireg    <= '0;
		end else begin
			cmd_stb <= 1'b0;
			if (sf_clr)
				sf <= 1'b0;                    // Command finished
			if (bus.wr_stb) begin
				case (bus.addr)
					ADDR_IREG0:  ireg[0] <= bus.wdata;
					ADDR_IREG1:  ireg[1] <= bus.wdata;
					ADDR_IREG2:  ireg[2] <= bus.wdata;
					ADDR_IREG3:  ireg[3] <= bus.wdata;
					ADDR_IREG4:  ireg[4] <= bus.wdata;
					ADDR_IREG5:  ireg[5] <= bus.wdata;
					ADDR_IREG6:  ireg[6] <= bus.wdata;
					ADDR_COMREG: cmd_stb <= 1'b1;
					ADDR_SF: begin
						if (bus.wdata[0])
							sf <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (bus.wr_stb && bus.addr == ADDR_COMREG)
			cmd <= cmd_code_t'(bus.wdata);   // Unknown codes kept as written
		if (bus.rd_stb) begin
			if (in_oreg) begin
				rd_data <= oreg_q;
			end else begin
				case (bus.addr)
					ADDR_SR: rd_data <= sr;
					ADDR_SF: rd_data <= {7'b1111000, sf};
					default: rd_data <= 8'h00;
				endcase
			end
		end
	end

	// Host side is a single master
	a_no_rd_wr_overlap: assert property (@(posedge CLK) disable iff (!RST_N)
		!(bus.wr_stb && bus.rd_stb));

endmodule

`default_nettype wire

//--- smpc_oreg_ram.sv
`default_nettype none

module smpc_oreg_ram import smpc_pkg::*; (
	input  logic       CLK,
	input  oreg_wr_t   wr,
	input  oreg_addr_t rd_addr,
	output byte_t      q
);

	byte_t mem [0:31];

	always_ff @(posedge CLK) begin
		if (wr.we)
			mem[wr.addr] <= wr.data;
	end

	assign q = mem[rd_addr];   // Async read, host registers it

endmodule

`default_nettype wire

//--- smpc_pkg.sv
`default_nettype none

package smpc_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [5:0] reg_addr_t;      // Host address A
	typedef logic [4:0] oreg_addr_t;
	typedef logic [3:0] area_code_t;
	typedef logic [7:0] bcd8_t;          // Two BCD digits

	// Same order as IREG0..IREG6 so a SETTIME payload maps straight across
	typedef struct packed {
		logic [15:0] year;
		logic [3:0]  dow;
		logic [3:0]  month;                // Binary 1..12
		bcd8_t       days;
		bcd8_t       hour;
		bcd8_t       minute;
		bcd8_t       second;
	} rtc_time_t;

	typedef byte_t [0:6] ireg_t;         // IREG0 in the top byte

	typedef struct packed {
		logic      wr_stb;
		logic      rd_stb;
		reg_addr_t addr;
		byte_t     wdata;
	} bus_req_t;

	typedef struct packed {
		logic       we;
		oreg_addr_t addr;
		byte_t      data;
	} oreg_wr_t;

	typedef struct packed {
		logic mshres_n;
		logic mshnmi_n;
		logic sshres_n;
		logic sshnmi_n;
		logic sysres_n;
		logic sndres_n;
		logic cdres_n;
		logic mirq_n;
	} sys_reset_t;

	typedef enum logic [7:0] {
		CMD_MSHON   = 8'h00,
		CMD_SSHON   = 8'h02,
		CMD_SSHOFF  = 8'h03,
		CMD_SNDON   = 8'h06,
		CMD_SNDOFF  = 8'h07,
		CMD_CDON    = 8'h08,
		CMD_CDOFF   = 8'h09,
		CMD_INTBACK = 8'h10,
		CMD_SETTIME = 8'h16,
		CMD_NMIREQ  = 8'h18,
		CMD_RESENAB = 8'h19,
		CMD_RESDISA = 8'h1A
	} cmd_code_t;

	typedef enum logic [2:0] {
		IDLE,
		WAIT,
		COMMAND,
		EXEC,
		END
	} seq_state_t;

	localparam reg_addr_t ADDR_IREG0  = 6'h00;
	localparam reg_addr_t ADDR_IREG1  = 6'h01;
	localparam reg_addr_t ADDR_IREG2  = 6'h02;
	localparam reg_addr_t ADDR_IREG3  = 6'h03;
	localparam reg_addr_t ADDR_IREG4  = 6'h04;
	localparam reg_addr_t ADDR_IREG5  = 6'h05;
	localparam reg_addr_t ADDR_IREG6  = 6'h06;
	localparam reg_addr_t ADDR_COMREG = 6'h0F;
	localparam reg_addr_t ADDR_SR     = 6'h30;
	localparam reg_addr_t ADDR_SF     = 6'h31;
	localparam reg_addr_t OREG_BASE   = 6'h10;   // OREG0..OREG31 at 10..2F

	// Command waits in CE cycles
	localparam logic [15:0] WAIT_ACCEPT  = 16'd60;
	localparam logic [15:0] WAIT_POWER   = 16'd60;
	localparam logic [15:0] WAIT_CD      = 16'd100;
	localparam logic [15:0] WAIT_MISC    = 16'd70;
	localparam logic [15:0] WAIT_SETTIME = 16'd220;
	localparam logic [15:0] WAIT_INTBACK = 16'd800;

	localparam oreg_addr_t OREG_ECHO   = 5'd31;
	localparam byte_t      INTBACK_KEY = 8'hF0;

endpackage

`default_nettype wire
